/* xbus_defines.svh */
// System bus address map and timing
`ifndef XBUS_DEFINES_SVH
`define XBUS_DEFINES_SVH

// The spy port lives in a 64-word block at this octal base.
`define XBUS_SPY_BASE 22'o17766000

// Low address bits ignored by the spy decode, which sets the block size.
`define XBUS_SPY_BLOCK_BITS 6

// Word memory depth, mapped from address zero upward.
`define XBUS_RAM_WORDS 256

// Cycles from req to the nonexistent-memory ack when no slave decodes.
`define XBUS_NXM_CYCLES 8

`endif

/* xbus_pkg.sv */
// System bus types
package xbus_pkg;

   // word address on the bus.
   typedef logic [21:0] xbus_addr_t;

   // bus data word.
   typedef logic [31:0] xbus_data_t;

   // data held in one spy register.
   typedef logic [15:0] spy_data_t;

   // spy register number, taken from the low address bits.
   typedef logic [3:0] spy_sel_t;

   // control FSM states.
   // ST_BUSY waits for a decode, ST_NXM holds the timeout ack and
   // ST_DONE waits for the host to drop req after a slave answered.
   typedef enum logic [1:0]
   {
      ST_IDLE = 2'd0,
      ST_BUSY = 2'd1,
      ST_NXM  = 2'd2,
      ST_DONE = 2'd3
   } ctrl_state_t;

endpackage

/* xbus_ctrl.sv */
// System bus control
`timescale 1ns/1ns
`include "xbus_defines.svh"

module xbus_ctrl
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req,
   input  logic                 spy_decode,
   input  logic                 ram_decode,
   input  logic                 spy_ack,
   input  logic                 ram_ack,
   input  xbus_pkg::xbus_data_t spy_rdata,
   input  xbus_pkg::xbus_data_t ram_rdata,
   output logic                 ack,
   output logic                 nxm,
   output xbus_pkg::xbus_data_t dataout
);

   localparam int cnt_bits = $clog2(`XBUS_NXM_CYCLES + 1);
   localparam logic [cnt_bits-1:0] last_wait = cnt_bits'(`XBUS_NXM_CYCLES - 1);

   xbus_pkg::ctrl_state_t state;
   xbus_pkg::ctrl_state_t state_next;
   logic [cnt_bits-1:0]   wait_cnt;
   logic                  hit;

   // some slave claims the current address.
   assign hit = spy_decode | ram_decode;

   always_comb
   begin
      state_next = state;
      case (state)
         xbus_pkg::ST_IDLE:
         begin
            if (req)
               state_next = xbus_pkg::ST_BUSY;
         end
         xbus_pkg::ST_BUSY:
         begin
            if (!req)
               state_next = xbus_pkg::ST_IDLE;
            else if (hit)
               state_next = xbus_pkg::ST_DONE;
            else if (wait_cnt == last_wait)
               state_next = xbus_pkg::ST_NXM;
         end
         xbus_pkg::ST_NXM,
         xbus_pkg::ST_DONE:
         begin
            if (!req)
               state_next = xbus_pkg::ST_IDLE;
         end
         default:
         begin
            state_next = xbus_pkg::ST_IDLE;
         end
      endcase
   end

   // the counter is preset to one while idle, so it holds the number of
   // cycles since req rose and the timeout lands on cycle XBUS_NXM_CYCLES.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= xbus_pkg::ST_IDLE;
         wait_cnt <= '0;
      end
      else
      begin
         state <= state_next;
         if (state == xbus_pkg::ST_IDLE)
            wait_cnt <= cnt_bits'(1);
         else if (state == xbus_pkg::ST_BUSY)
            wait_cnt <= wait_cnt + 1'b1;
      end
   end

   // nxm follows req down in the same cycle the host releases it.
   assign nxm = (state == xbus_pkg::ST_NXM) && req;

   assign ack = spy_ack | ram_ack | nxm;

   // steer the decoding slave's data; an undecoded request reads zero.
   always_comb
   begin
      if (spy_decode)
         dataout = spy_rdata;
      else if (ram_decode)
         dataout = ram_rdata;
      else
         dataout = '0;
   end

endmodule

/* xbus_spy.sv */
// Spy port bus slave
`timescale 1ns/1ns
`include "xbus_defines.svh"

module xbus_spy
(
   input  logic                 clk,
   input  logic                 reset,
   input  xbus_pkg::xbus_addr_t addr,
   input  xbus_pkg::xbus_data_t datain,
   input  logic                 req,
   input  logic                 write,
   output xbus_pkg::xbus_data_t dataout,
   output logic                 ack,
   output logic                 decode,
   input  xbus_pkg::spy_data_t  spy_rdata,
   output xbus_pkg::spy_data_t  spy_wdata,
   output xbus_pkg::spy_sel_t   spy_sel,
   output logic                 spy_wr,
   output logic                 spy_rd
);

   localparam int addr_msb = $bits(xbus_pkg::xbus_addr_t) - 1;
   localparam xbus_pkg::xbus_addr_t spy_base = `XBUS_SPY_BASE;

   logic [2:0] ack_delay;
   logic [1:0] strobe;
   logic       first_cycle;
   logic       read_capture;

   assign decode = req &&
      (addr[addr_msb:`XBUS_SPY_BLOCK_BITS] == spy_base[addr_msb:`XBUS_SPY_BLOCK_BITS]);

   // the first decoded cycle is the one where the delay line is still empty.
   assign first_cycle = decode && !ack_delay[0];

   assign ack     = ack_delay[2];
   assign spy_sel = addr[$bits(xbus_pkg::spy_sel_t)-1:0];

   // ack is decode three cycles late and drains the same way after req drops.
   // strobe carries a single pulse one and two cycles after the request starts.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_delay <= '0;
         strobe    <= '0;
      end
      else
      begin
         ack_delay <= {ack_delay[1:0], decode};
         strobe    <= {strobe[0], first_cycle};
      end
   end

   assign spy_rd       = strobe[0] && !write;
   assign spy_wr       = strobe[0] && write;
   assign read_capture = strobe[1] && !write;

   // the register bank has its read data ready one cycle after spy_rd.
   always_ff @(posedge clk)
   begin
      if (reset)
         dataout <= '0;
      else if (read_capture)
         dataout <= xbus_pkg::xbus_data_t'(spy_rdata);
   end

   always_ff @(posedge clk)
   begin
      if (first_cycle && write)
         spy_wdata <= datain[$bits(xbus_pkg::spy_data_t)-1:0];
   end

endmodule

/* spy_regs.sv */
// Spy register bank
`timescale 1ns/1ns

module spy_regs
(
   input  logic                clk,
   input  logic                reset,
   input  xbus_pkg::spy_sel_t  spy_sel,
   input  xbus_pkg::spy_data_t spy_wdata,
   input  logic                spy_wr,
   input  logic                spy_rd,
   output xbus_pkg::spy_data_t spy_rdata
);

   localparam int num_regs = 2 ** $bits(xbus_pkg::spy_sel_t);

   xbus_pkg::spy_data_t regs [num_regs];

   // the bank is visible state on the front panel, so reset clears it.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < num_regs; i++)
            regs[i] <= '0;
      end
      else if (spy_wr)
      begin
         regs[spy_sel] <= spy_wdata;
      end
   end

   // read data is held until the next spy_rd.
   always_ff @(posedge clk)
   begin
      if (reset)
         spy_rdata <= '0;
      else if (spy_rd)
         spy_rdata <= regs[spy_sel];
   end

endmodule

/* xbus_ram.sv */
// Word memory bus slave
`timescale 1ns/1ns
`include "xbus_defines.svh"

module xbus_ram
(
   input  logic                 clk,
   input  logic                 reset,
   input  xbus_pkg::xbus_addr_t addr,
   input  xbus_pkg::xbus_data_t datain,
   input  logic                 req,
   input  logic                 write,
   output xbus_pkg::xbus_data_t dataout,
   output logic                 ack,
   output logic                 decode
);

   localparam int index_bits = $clog2(`XBUS_RAM_WORDS);

   xbus_pkg::xbus_data_t   mem [`XBUS_RAM_WORDS];
   logic [index_bits-1:0] index;
   logic                  ack_q;

   assign decode = req && (addr < `XBUS_RAM_WORDS);
   assign index  = addr[index_bits-1:0];
   assign ack    = ack_q;

   // ack trails decode by one cycle on both edges.
   always_ff @(posedge clk)
   begin
      if (reset)
         ack_q <= 1'b0;
      else
         ack_q <= decode;
   end

   // write once, on the first decoded edge.
   always_ff @(posedge clk)
   begin
      if (decode && !ack_q && write)
         mem[index] <= datain;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         dataout <= '0;
      else if (decode && !write)
         dataout <= mem[index];
   end

endmodule

/* xbus_top.sv */
// System bus subsystem top
`timescale 1ns/1ns

module xbus_top
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req,
   input  logic                 write,
   input  xbus_pkg::xbus_addr_t addr,
   input  xbus_pkg::xbus_data_t datain,
   output xbus_pkg::xbus_data_t dataout,
   output logic                 ack,
   output logic                 nxm
);

   logic                 spy_decode;
   logic                 spy_ack;
   xbus_pkg::xbus_data_t spy_dout;
   logic                 ram_decode;
   logic                 ram_ack;
   xbus_pkg::xbus_data_t ram_dout;

   // spy side between the port and the register bank.
   xbus_pkg::spy_data_t  spy_rdata;
   xbus_pkg::spy_data_t  spy_wdata;
   xbus_pkg::spy_sel_t   spy_sel;
   logic                 spy_wr;
   logic                 spy_rd;

   xbus_ctrl i_ctrl
   (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .spy_decode (spy_decode),
      .ram_decode (ram_decode),
      .spy_ack    (spy_ack),
      .ram_ack    (ram_ack),
      .spy_rdata  (spy_dout),
      .ram_rdata  (ram_dout),
      .ack        (ack),
      .nxm        (nxm),
      .dataout    (dataout)
   );

   xbus_spy i_spy
   (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .datain    (datain),
      .req       (req),
      .write     (write),
      .dataout   (spy_dout),
      .ack       (spy_ack),
      .decode    (spy_decode),
      .spy_rdata (spy_rdata),
      .spy_wdata (spy_wdata),
      .spy_sel   (spy_sel),
      .spy_wr    (spy_wr),
      .spy_rd    (spy_rd)
   );

   spy_regs i_spy_regs
   (
      .clk       (clk),
      .reset     (reset),
      .spy_sel   (spy_sel),
      .spy_wdata (spy_wdata),
      .spy_wr    (spy_wr),
      .spy_rd    (spy_rd),
      .spy_rdata (spy_rdata)
   );

   xbus_ram i_ram
   (
      .clk     (clk),
      .reset   (reset),
      .addr    (addr),
      .datain  (datain),
      .req     (req),
      .write   (write),
      .dataout (ram_dout),
      .ack     (ram_ack),
      .decode  (ram_decode)
   );

endmodule

/* tb_xbus_top.sv */
// System bus subsystem testbench
`timescale 1ns/1ns
`include "xbus_defines.svh"

module tb_xbus_top;

   localparam int mem_tests = 32;
   localparam int mix_tests = 200;
   // reset reads, memory, spy writes and block reads, nxm with readback, random mix.
   localparam int num_bus_cycles = 16 + 2 * mem_tests + 16 + 64 + 8 + 16 + mem_tests + mix_tests;

   // one finished bus cycle, with what the model expected and what the DUT gave.
   typedef struct {
      xbus_pkg::xbus_addr_t addr;
      logic                 check_dout;
      xbus_pkg::xbus_data_t exp_data;
      xbus_pkg::xbus_data_t act_data;
      logic                 exp_nxm;
      logic                 act_nxm;
      int                   exp_cycles;
      int                   act_cycles;
   } result_t;

   logic                 clk;
   logic                 reset;
   logic                 req;
   logic                 write;
   xbus_pkg::xbus_addr_t addr;
   xbus_pkg::xbus_data_t datain;
   xbus_pkg::xbus_data_t dataout;
   logic                 ack;
   logic                 nxm;

   xbus_pkg::xbus_data_t model_mem [`XBUS_RAM_WORDS];
   logic                 mem_valid [`XBUS_RAM_WORDS];
   xbus_pkg::spy_data_t  model_spy [16];
   xbus_pkg::xbus_addr_t mem_addrs [mem_tests];
   result_t              results [$];
   int                   checks;
   int                   errors;
   int                   chk_base;
   int                   err_base;

   xbus_top i_dut
   (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .write   (write),
      .addr    (addr),
      .datain  (datain),
      .dataout (dataout),
      .ack     (ack),
      .nxm     (nxm)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // 0 for word memory, 1 for the spy block, 2 for unmapped space.
   function automatic int addr_kind(input xbus_pkg::xbus_addr_t a);
      xbus_pkg::xbus_addr_t base;
      int kind;
      base = `XBUS_SPY_BASE;
      kind = 2;
      if (int'(a) < `XBUS_RAM_WORDS)
         kind = 0;
      else if (a[21:6] == base[21:6])
         kind = 1;
      return kind;
   endfunction

   function automatic xbus_pkg::xbus_data_t ref_read(input xbus_pkg::xbus_addr_t a,
                                                    output logic exp_nxm);
      xbus_pkg::xbus_data_t value;
      value   = '0;
      exp_nxm = 1'b0;
      case (addr_kind(a))
         0: value = model_mem[int'(a)];
         1: value = {16'h0000, model_spy[a[3:0]]};
         default: exp_nxm = 1'b1;
      endcase
      return value;
   endfunction

   function automatic int expected_cycles(input xbus_pkg::xbus_addr_t a);
      int kind;
      kind = addr_kind(a);
      if (kind == 0)
         return 1;
      else if (kind == 1)
         return 3;
      return `XBUS_NXM_CYCLES;
   endfunction

   function automatic xbus_pkg::xbus_addr_t spy_addr(input int offset);
      xbus_pkg::xbus_addr_t a;
      a      = `XBUS_SPY_BASE;
      a[5:0] = 6'(offset);
      return a;
   endfunction

   function automatic xbus_pkg::xbus_addr_t random_unmapped();
      xbus_pkg::xbus_addr_t a;
      do
         a = xbus_pkg::xbus_addr_t'($urandom);
      while (addr_kind(a) != 2);
      return a;
   endfunction

   // an unmapped address whose low byte lands on the given memory word.
   function automatic xbus_pkg::xbus_addr_t unmapped_alias(input xbus_pkg::xbus_addr_t low);
      xbus_pkg::xbus_addr_t a;
      do
      begin
         a      = xbus_pkg::xbus_addr_t'($urandom);
         a[7:0] = low[7:0];
      end
      while (addr_kind(a) != 2);
      return a;
   endfunction

   function automatic void model_write(input xbus_pkg::xbus_addr_t a,
                                       input xbus_pkg::xbus_data_t d);
      case (addr_kind(a))
         0:
         begin
            model_mem[int'(a)] = d;
            mem_valid[int'(a)] = 1'b1;
         end
         1: model_spy[a[3:0]] = d[15:0];
         default: ;
      endcase
   endfunction

   task automatic check_data(input string name, input xbus_pkg::xbus_addr_t a,
                             input xbus_pkg::xbus_data_t got,
                             input xbus_pkg::xbus_data_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error: %s at addr 0x%h: got 0x%h, expected 0x%h", name, a, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input xbus_pkg::xbus_addr_t a,
                             input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error: %s at addr 0x%h: got 0x%h, expected 0x%h", name, a, got, exp);
      end
   endtask

   task automatic check_latency(input xbus_pkg::xbus_addr_t a, input int got, input int exp);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("ack came %0d cycles after req at address 0x%h instead of %0d cycles",
                  got, a, exp);
      end
   endtask

   // one request under the host rule; inputs change on rising edges, outputs
   // are sampled on falling edges.
   task automatic bus_cycle(input logic wr, input xbus_pkg::xbus_addr_t a,
                            input xbus_pkg::xbus_data_t d);
      result_t r;
      logic    exp_nxm;
      r.addr       = a;
      r.exp_data   = ref_read(a, exp_nxm);
      r.exp_nxm    = exp_nxm;
      r.check_dout = !wr || exp_nxm;
      r.exp_cycles = expected_cycles(a);
      r.act_cycles = 0;
      @(posedge clk);
      req    <= 1'b1;
      write  <= wr;
      addr   <= a;
      datain <= d;
      // an ack already up in the cycle req rises counts as zero cycles.
      @(negedge clk);
      while (!ack)
      begin
         @(posedge clk);
         r.act_cycles++;
         @(negedge clk);
      end
      r.act_data = dataout;
      r.act_nxm  = nxm;
      if (wr)
         model_write(a, d);
      results.push_back(r);
      @(posedge clk);
      req <= 1'b0;
      // the spy delay line may keep ack up for a few more cycles.
      do
         @(negedge clk);
      while (ack);
   endtask

   task automatic report_test(input string name);
      while (results.size() != 0)
         @(negedge clk);
      $display("test %s finished: %0d checks, %0d errors", name,
               checks - chk_base, errors - err_base);
      chk_base = checks;
      err_base = errors;
   endtask

   // compare process.
   initial
   begin
      result_t r;
      forever
      begin
         @(posedge clk);
         while (results.size() > 0)
         begin
            r = results.pop_front();
            if (r.check_dout)
               check_data("dataout", r.addr, r.act_data, r.exp_data);
            check_flag("nxm", r.addr, r.act_nxm, r.exp_nxm);
            check_latency(r.addr, r.act_cycles, r.exp_cycles);
         end
      end
   end

   initial
   begin
      repeat (num_bus_cycles * 20 + 100) @(posedge clk);
      $display("timeout: the run did not finish within %0d clocks",
               num_bus_cycles * 20 + 100);
      $display("Test failures found");
      $finish;
   end

   initial
   begin
      xbus_pkg::xbus_addr_t a;
      int unsigned          rnd;
      int                   kind;
      logic                 wr;
      rnd      = $urandom(51);
      reset    = 1'b1;
      req      = 1'b0;
      write    = 1'b0;
      addr     = '0;
      datain   = '0;
      checks   = 0;
      errors   = 0;
      chk_base = 0;
      err_base = 0;
      for (int i = 0; i < 16; i++)
         model_spy[i] = '0;
      for (int i = 0; i < `XBUS_RAM_WORDS; i++)
         mem_valid[i] = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      @(negedge clk);
      check_flag("ack", '0, ack, 1'b0);
      check_flag("nxm", '0, nxm, 1'b0);
      for (int i = 0; i < 16; i++)
         bus_cycle(1'b0, spy_addr(i), '0);
      report_test("after reset");

      for (int i = 0; i < mem_tests; i++)
      begin
         a = xbus_pkg::xbus_addr_t'($urandom % `XBUS_RAM_WORDS);
         mem_addrs[i] = a;
         bus_cycle(1'b1, a, $urandom);
      end
      for (int i = 0; i < mem_tests; i++)
         bus_cycle(1'b0, mem_addrs[i], '0);
      report_test("memory");

      // writes go through random aliases, then the whole block is read back.
      for (int i = 0; i < 16; i++)
         bus_cycle(1'b1, spy_addr(int'({2'($urandom), 4'(i)})), $urandom);
      for (int i = 0; i < 64; i++)
         bus_cycle(1'b0, spy_addr(i), '0);
      report_test("spy port");

      // unmapped writes share their low byte with memory words read back below.
      for (int i = 0; i < 8; i++)
         bus_cycle(i % 2 == 0, unmapped_alias(mem_addrs[i]), $urandom);
      for (int i = 0; i < 16; i++)
         bus_cycle(1'b0, spy_addr(i), '0);
      for (int i = 0; i < mem_tests; i++)
         bus_cycle(1'b0, mem_addrs[i], '0);
      report_test("nonexistent memory");

      for (int i = 0; i < mix_tests; i++)
      begin
         kind = int'($urandom % 3);
         rnd  = $urandom;
         wr   = rnd[0];
         if (kind == 0)
            a = xbus_pkg::xbus_addr_t'($urandom % `XBUS_RAM_WORDS);
         else if (kind == 1)
            a = spy_addr(int'($urandom % 64));
         else
            a = random_unmapped();
         // memory holds no known value until it has been written.
         if (kind == 0 && !mem_valid[int'(a)])
            wr = 1'b1;
         bus_cycle(wr, a, $urandom);
      end
      report_test("random mix");

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* xbus_top.f */
+incdir+.
xbus_pkg.sv
xbus_ctrl.sv
xbus_spy.sv
spy_regs.sv
xbus_ram.sv
xbus_top.sv
tb_xbus_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_xbus_top
FILELIST  := xbus_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
